// File: src/cpuDefs.svh
// ========================================
// Sizes shared by the core and testbench
// INSTR_CREDITS must be a power of two, at least 2
// ========================================
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Number of architectural registers, register 0 is hardwired to zero
`define REG_COUNT 64

// Operand and result width in bits
`define DATA_WIDTH 64

// Instruction buffer depth, also the input credits owned by the source
`define INSTR_CREDITS 2

// Output credits the core owns after reset
`define RES_CREDITS 4

`endif

// File: src/cpuPkg.sv
// ========================================
// Types for the integer path of the core
// Only the executed subset has encodings
// ========================================
`include "cpuDefs.svh"

package cpuPkg;

	typedef logic [5:0] regspec_t;

	// ========================================
	// Instruction encodings
	// ========================================
	typedef enum logic [6:0] {
		OP_R2    = 7'd2,
		OP_ADDI  = 7'd4,
		OP_SUBFI = 7'd5,
		OP_CMPI  = 7'd6,
		OP_MULI  = 7'd7,
		OP_ANDI  = 7'd8,
		OP_ORI   = 7'd9,
		OP_EORI  = 7'd10,
		OP_SLTI  = 7'd11,
		OP_MOV   = 7'd12
	} opcode_e;

	// Function codes live in the tail field of OP_R2
	typedef enum logic [6:0] {
		FN_CMP  = 7'd3,
		FN_ADD  = 7'd4,
		FN_SUB  = 7'd5,
		FN_MUL  = 7'd6,
		FN_AND  = 7'd8,
		FN_OR   = 7'd9,
		FN_EOR  = 7'd10,
		FN_ANDC = 7'd11,
		FN_NAND = 7'd12,
		FN_NOR  = 7'd13,
		FN_ENOR = 7'd14,
		FN_ORC  = 7'd15,
		FN_SEQ  = 7'd80,
		FN_SNE  = 7'd81,
		FN_SLT  = 7'd82,
		FN_SLE  = 7'd83,
		FN_SLTU = 7'd84,
		FN_SLEU = 7'd85
	} func_e;

	// For immediate forms {tail, Rb} is a 13-bit signed immediate
	typedef struct packed {
		logic [6:0] tail;
		regspec_t   Rb;
		regspec_t   Ra;
		regspec_t   Rt;
		opcode_e    opcode;
	} instruction_t;

	// ========================================
	// Pipeline types
	// ========================================
	// Immediate forms share these; SUBF is operand B minus operand A
	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SUBF, ALU_CMP, ALU_MUL,
		ALU_AND, ALU_OR, ALU_EOR, ALU_ANDC, ALU_NAND,
		ALU_NOR, ALU_ENOR, ALU_ORC, ALU_SEQ, ALU_SNE,
		ALU_SLT, ALU_SLE, ALU_SLTU, ALU_SLEU, ALU_MOV
	} aluOp_e;

	// Decode register contents, operands as read from the register file
	typedef struct packed {
		logic                   valid;
		aluOp_e                 aluOp;
		logic                   useImm;
		regspec_t               Ra;
		regspec_t               Rb;
		regspec_t               Rt;
		logic [`DATA_WIDTH-1:0] opA;
		logic [`DATA_WIDTH-1:0] opB;
		logic                   illegal;
	} decodeBus_t;

	typedef struct packed {
		logic                   valid;
		regspec_t               Rt;
		logic [`DATA_WIDTH-1:0] value;
		logic                   illegal;
	} execBus_t;

	typedef struct packed {
		regspec_t               Rt;
		logic [`DATA_WIDTH-1:0] value;
		logic                   illegal;
	} resultBus_t;

endpackage

// File: src/decodeRt.sv
// ========================================
// Target register decode, pure combinational
// Anything outside the executed subset targets register 0
// ========================================
`timescale 1ns/10ps

module decodeRt (
	input  cpuPkg::instruction_t instr,
	output cpuPkg::regspec_t     Rt
);

	import cpuPkg::*;

	always_comb
	begin
		Rt = '0;
		case (instr.opcode)
			// Register-register forms only write back for the supported functions
			OP_R2:
			begin
				case (func_e'(instr.tail))
					FN_ADD, FN_SUB, FN_CMP, FN_MUL,
					FN_AND, FN_OR, FN_EOR, FN_ANDC,
					FN_NAND, FN_NOR, FN_ENOR, FN_ORC,
					FN_SEQ, FN_SNE, FN_SLT, FN_SLE,
					FN_SLTU, FN_SLEU:
						Rt = instr.Rt;
					default:
						Rt = '0;
				endcase
			end
			// Immediate forms keep Rt in the same place as OP_R2
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_SLTI,
			OP_ANDI, OP_ORI, OP_EORI:
				Rt = instr.Rt;
			OP_MOV:
				Rt = instr.Rt;
			// Unknown opcodes still flow down the pipe but never write
			default:
				Rt = '0;
		endcase
	end

endmodule

// File: src/regFile.sv
// ========================================
// 64 x 64 register file, two reads and one write
// Reads are combinational and see a write in the same cycle
// ========================================
`timescale 1ns/10ps
`include "cpuDefs.svh"

module regFile (
	input  logic                   clk,
	input  logic                   we,
	input  cpuPkg::regspec_t       wrAddr,
	input  logic [`DATA_WIDTH-1:0] wrData,
	input  cpuPkg::regspec_t       rdAddrA,
	input  cpuPkg::regspec_t       rdAddrB,
	output logic [`DATA_WIDTH-1:0] rdDataA,
	output logic [`DATA_WIDTH-1:0] rdDataB
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// Register 0 is never stored, its read is forced to zero below
	always_ff @(posedge clk)
	begin
		if (we && wrAddr != '0)
			regs[wrAddr] <= wrData;
	end

	// Bypass covers the instruction two ahead that writes back this cycle
	always_comb
	begin
		if (rdAddrA == '0)
			rdDataA = '0;
		else if (we && rdAddrA == wrAddr)
			rdDataA = wrData;
		else
			rdDataA = regs[rdAddrA];
	end

	always_comb
	begin
		if (rdAddrB == '0)
			rdDataB = '0;
		else if (we && rdAddrB == wrAddr)
			rdDataB = wrData;
		else
			rdDataB = regs[rdAddrB];
	end

	// Writeback control upstream already filters out register 0
	a_noWriteZero: assert property (@(posedge clk) we |-> wrAddr != '0);

endmodule

// File: src/decodeStage.sv
// ========================================
// Instruction buffer, field decode and register read
// Source must respect its credits, a push into a full buffer is lost
// ========================================
`timescale 1ns/10ps
`include "cpuDefs.svh"

module decodeStage (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   instrValid,
	input  cpuPkg::instruction_t   instr,
	input  logic                   stall,
	output cpuPkg::regspec_t       rdAddrA,
	output cpuPkg::regspec_t       rdAddrB,
	input  logic [`DATA_WIDTH-1:0] rdDataA,
	input  logic [`DATA_WIDTH-1:0] rdDataB,
	output logic                   instrCredit,
	output cpuPkg::decodeBus_t     decodeBus
);

	import cpuPkg::*;

	localparam int PtrW = $clog2(`INSTR_CREDITS);
	localparam int CntW = $clog2(`INSTR_CREDITS + 1);

	// ========================================
	// Instruction buffer
	// ========================================
	instruction_t          fifoMem [`INSTR_CREDITS];
	logic [PtrW-1:0]       wrPtr;
	logic [PtrW-1:0]       rdPtr;
	logic [CntW-1:0]       count;
	logic                  empty;
	logic                  full;
	logic                  pop;
	instruction_t          head;
	regspec_t              headRt;
	decodeBus_t            nextBus;

	assign empty = (count == '0);
	assign full  = (count == CntW'(`INSTR_CREDITS));
	// The head advances together with the rest of the pipe
	assign pop   = !stall && !empty;
	assign head  = fifoMem[rdPtr];

	// Storage has no reset, only the pointers do
	always_ff @(posedge clk)
	begin
		if (instrValid)
			fifoMem[wrPtr] <= instr;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr       <= '0;
			rdPtr       <= '0;
			count       <= '0;
			instrCredit <= 1'b0;
		end
		else
		begin
			if (instrValid)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			count       <= count + CntW'(instrValid) - CntW'(pop);
			// One credit goes back for each entry that leaves
			instrCredit <= pop;
		end
	end

	// ========================================
	// Field decode of the buffer head
	// ========================================
	decodeRt i_decodeRt (
		.instr(head),
		.Rt   (headRt)
	);

	// Register read runs straight off the head
	assign rdAddrA = head.Ra;
	assign rdAddrB = head.Rb;

	always_comb
	begin
		nextBus         = '0;
		nextBus.valid   = !empty;
		nextBus.Ra      = head.Ra;
		nextBus.Rb      = head.Rb;
		nextBus.Rt      = headRt;
		nextBus.opA     = rdDataA;
		nextBus.opB     = rdDataB;
		nextBus.useImm  = 1'b1;
		nextBus.aluOp   = ALU_ADD;
		case (head.opcode)
			OP_R2:
			begin
				nextBus.useImm = 1'b0;
				case (func_e'(head.tail))
					FN_ADD:  nextBus.aluOp = ALU_ADD;
					FN_SUB:  nextBus.aluOp = ALU_SUB;
					FN_CMP:  nextBus.aluOp = ALU_CMP;
					FN_MUL:  nextBus.aluOp = ALU_MUL;
					FN_AND:  nextBus.aluOp = ALU_AND;
					FN_OR:   nextBus.aluOp = ALU_OR;
					FN_EOR:  nextBus.aluOp = ALU_EOR;
					FN_ANDC: nextBus.aluOp = ALU_ANDC;
					FN_NAND: nextBus.aluOp = ALU_NAND;
					FN_NOR:  nextBus.aluOp = ALU_NOR;
					FN_ENOR: nextBus.aluOp = ALU_ENOR;
					FN_ORC:  nextBus.aluOp = ALU_ORC;
					FN_SEQ:  nextBus.aluOp = ALU_SEQ;
					FN_SNE:  nextBus.aluOp = ALU_SNE;
					FN_SLT:  nextBus.aluOp = ALU_SLT;
					FN_SLE:  nextBus.aluOp = ALU_SLE;
					FN_SLTU: nextBus.aluOp = ALU_SLTU;
					FN_SLEU: nextBus.aluOp = ALU_SLEU;
					default: nextBus.illegal = 1'b1;
				endcase
			end
			OP_ADDI:  nextBus.aluOp = ALU_ADD;
			// Immediate minus Ra
			OP_SUBFI: nextBus.aluOp = ALU_SUBF;
			OP_CMPI:  nextBus.aluOp = ALU_CMP;
			OP_MULI:  nextBus.aluOp = ALU_MUL;
			OP_SLTI:  nextBus.aluOp = ALU_SLT;
			OP_ANDI:  nextBus.aluOp = ALU_AND;
			OP_ORI:   nextBus.aluOp = ALU_OR;
			OP_EORI:  nextBus.aluOp = ALU_EOR;
			OP_MOV:   nextBus.aluOp = ALU_MOV;
			default:  nextBus.illegal = 1'b1;
		endcase
		// Immediate is bits 31..19, sign extended
		if (nextBus.useImm)
			nextBus.opB = {{(`DATA_WIDTH-13){head.tail[6]}}, head.tail, head.Rb};
	end

	// Decode register, only valid is cleared by reset
	always_ff @(posedge clk)
	begin
		if (rst)
			decodeBus.valid <= 1'b0;
		else if (!stall)
			decodeBus <= nextBus;
	end

	// The source only pushes with a credit in hand, so it never finds the buffer full
	a_noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
		!(instrValid && full));

endmodule

// File: src/executeStage.sv
// ========================================
// ALU with forwarding and the execute register
// Single-cycle ops only, MUL keeps the low half
// ========================================
`timescale 1ns/10ps
`include "cpuDefs.svh"

module executeStage (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall,
	input  cpuPkg::decodeBus_t decodeBus,
	output cpuPkg::execBus_t   execBus
);

	import cpuPkg::*;

	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic                   fwdA;
	logic                   fwdB;
	logic                   sLt;
	logic                   uLt;
	logic                   isEq;

	// ========================================
	// Operand select
	// ========================================
	// The previous instruction sits in our own output register
	// Register 0 is never forwarded, it must read as zero
	assign fwdA = execBus.valid && execBus.Rt != '0 && decodeBus.Ra == execBus.Rt;
	assign fwdB = execBus.valid && execBus.Rt != '0 && decodeBus.Rb == execBus.Rt
		&& !decodeBus.useImm;

	assign opA = fwdA ? execBus.value : decodeBus.opA;
	assign opB = fwdB ? execBus.value : decodeBus.opB;

	assign sLt  = $signed(opA) < $signed(opB);
	assign uLt  = opA < opB;
	assign isEq = opA == opB;

	// ========================================
	// ALU
	// ========================================
	always_comb
	begin
		aluResult = '0;
		case (decodeBus.aluOp)
			ALU_ADD:  aluResult = opA + opB;
			ALU_SUB:  aluResult = opA - opB;
			ALU_SUBF: aluResult = opB - opA;
			// Signed compare gives -1, 0 or 1
			ALU_CMP:
			begin
				if (sLt)
					aluResult = '1;
				else if (!isEq)
					aluResult[0] = 1'b1;
			end
			ALU_MUL:  aluResult = opA * opB;
			ALU_AND:  aluResult = opA & opB;
			ALU_OR:   aluResult = opA | opB;
			ALU_EOR:  aluResult = opA ^ opB;
			ALU_ANDC: aluResult = opA & ~opB;
			ALU_NAND: aluResult = ~(opA & opB);
			ALU_NOR:  aluResult = ~(opA | opB);
			ALU_ENOR: aluResult = ~(opA ^ opB);
			ALU_ORC:  aluResult = opA | ~opB;
			// Set ops give 0 or 1
			ALU_SEQ:  aluResult[0] = isEq;
			ALU_SNE:  aluResult[0] = !isEq;
			ALU_SLT:  aluResult[0] = sLt;
			ALU_SLE:  aluResult[0] = sLt || isEq;
			ALU_SLTU: aluResult[0] = uLt;
			ALU_SLEU: aluResult[0] = uLt || isEq;
			ALU_MOV:  aluResult = opA;
			default:  aluResult = '0;
		endcase
	end

	// Execute register, holds while the result stage has no credit
	always_ff @(posedge clk)
	begin
		if (rst)
			execBus.valid <= 1'b0;
		else if (!stall)
		begin
			execBus.valid   <= decodeBus.valid;
			execBus.Rt      <= decodeBus.Rt;
			execBus.illegal <= decodeBus.illegal;
			// Illegal instructions carry a zero value
			execBus.value   <= decodeBus.illegal ? '0 : aluResult;
		end
	end

endmodule

// File: src/resultStage.sv
// ========================================
// Output credits, writeback and result register
// Consumer must never return more credits than it was sent beats
// ========================================
`timescale 1ns/10ps
`include "cpuDefs.svh"

module resultStage (
	input  logic                   clk,
	input  logic                   rst,
	input  cpuPkg::execBus_t       execBus,
	input  logic                   resCredit,
	output logic                   stall,
	output logic                   we,
	output cpuPkg::regspec_t       wrAddr,
	output logic [`DATA_WIDTH-1:0] wrData,
	output logic                   resValid,
	output cpuPkg::resultBus_t     res
);

	localparam int CrW = $clog2(`RES_CREDITS + 1);

	logic [CrW-1:0] credits;
	logic           issue;

	// A beat goes out whenever a result waits and a credit is held
	assign issue = execBus.valid && credits != '0;
	// A credit returned this cycle only counts from the next one
	assign stall = execBus.valid && credits == '0;

	// Writeback happens at the same edge as the beat is registered
	assign we     = issue && execBus.Rt != '0 && !execBus.illegal;
	assign wrAddr = execBus.Rt;
	assign wrData = execBus.value;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			credits  <= CrW'(`RES_CREDITS);
			resValid <= 1'b0;
		end
		else
		begin
			credits  <= credits - CrW'(issue) + CrW'(resCredit);
			resValid <= issue;
		end
	end

	// Result payload has no reset, resValid qualifies it
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			res.Rt      <= execBus.Rt;
			res.value   <= execBus.value;
			res.illegal <= execBus.illegal;
		end
	end

	// Consumer returns at most the credits it was given
	a_creditLimit: assert property (@(posedge clk) disable iff (rst)
		credits <= CrW'(`RES_CREDITS));

endmodule

// File: src/coreTop.sv
// ========================================
// Integer core top, four stages of wiring
// ========================================
`timescale 1ns/10ps
`include "cpuDefs.svh"

module coreTop (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 instrValid,
	input  cpuPkg::instruction_t instr,
	output logic                 instrCredit,
	output logic                 resValid,
	output cpuPkg::resultBus_t   res,
	input  logic                 resCredit
);

	import cpuPkg::*;

	// Register file ports
	regspec_t               rdAddrA;
	regspec_t               rdAddrB;
	logic [`DATA_WIDTH-1:0] rdDataA;
	logic [`DATA_WIDTH-1:0] rdDataB;
	logic                   we;
	regspec_t               wrAddr;
	logic [`DATA_WIDTH-1:0] wrData;

	// Pipeline links
	decodeBus_t             decodeBus;
	execBus_t               execBus;
	logic                   stall;

	decodeStage i_decode (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.stall      (stall),
		.rdAddrA    (rdAddrA),
		.rdAddrB    (rdAddrB),
		.rdDataA    (rdDataA),
		.rdDataB    (rdDataB),
		.instrCredit(instrCredit),
		.decodeBus  (decodeBus)
	);

	regFile i_regFile (
		.clk    (clk),
		.we     (we),
		.wrAddr (wrAddr),
		.wrData (wrData),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	executeStage i_execute (
		.clk      (clk),
		.rst      (rst),
		.stall    (stall),
		.decodeBus(decodeBus),
		.execBus  (execBus)
	);

	resultStage i_result (
		.clk      (clk),
		.rst      (rst),
		.execBus  (execBus),
		.resCredit(resCredit),
		.stall    (stall),
		.we       (we),
		.wrAddr   (wrAddr),
		.wrData   (wrData),
		.resValid (resValid),
		.res      (res)
	);

endmodule

// File: sim/tbRefModel.svh
// ========================================
// Reference model, included inside coreTb after the cpuPkg import
// Model registers start at zero, the DUT registers do not
// ========================================
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Separate generators so stimulus and credit return never share a state
logic [15:0] stimLfsr = 16'd19563;
logic [15:0] credLfsr = 16'd19563;

// Architectural state as the instruction set defines it
logic [`DATA_WIDTH-1:0] modelRegs [`REG_COUNT];

// Fibonacci LFSR, taps 16 14 13 11, new bit shifts in at bit 0
function automatic logic [15:0] lfsrNext(input logic [15:0] state);
	logic fb;
	fb = state[15] ^ state[13] ^ state[12] ^ state[10];
	return {state[14:0], fb};
endfunction

// One LFSR step for every bit handed out
function automatic logic [`DATA_WIDTH-1:0] randBits(input int n);
	logic [`DATA_WIDTH-1:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		stimLfsr = lfsrNext(stimLfsr);
		v = {v[`DATA_WIDTH-2:0], stimLfsr[0]};
	end
	return v;
endfunction

function automatic int randBelow(input int n);
	return int'(randBits(16)) % n;
endfunction

// ========================================
// Instruction builders
// ========================================
function automatic instruction_t mkR2(input func_e fn, input regspec_t rt,
	input regspec_t ra, input regspec_t rb);
	instruction_t ins;
	ins.opcode = OP_R2;
	ins.Rt     = rt;
	ins.Ra     = ra;
	ins.Rb     = rb;
	ins.tail   = fn;
	return ins;
endfunction

// The 13-bit immediate fills the tail and the Rb field
function automatic instruction_t mkImm(input opcode_e op, input regspec_t rt,
	input regspec_t ra, input logic [12:0] imm);
	instruction_t ins;
	ins.opcode         = op;
	ins.Rt             = rt;
	ins.Ra             = ra;
	{ins.tail, ins.Rb} = imm;
	return ins;
endfunction

// ========================================
// Reference execution
// ========================================
function automatic logic [`DATA_WIDTH-1:0] regVal(input regspec_t r);
	return (r == '0) ? '0 : modelRegs[r];
endfunction

// Signed three way compare giving -1, 0 or 1
function automatic logic [`DATA_WIDTH-1:0] cmpVal(input logic [`DATA_WIDTH-1:0] a,
	input logic [`DATA_WIDTH-1:0] b);
	if ($signed(a) < $signed(b))
		return '1;
	else if (a == b)
		return '0;
	return `DATA_WIDTH'(1);
endfunction

// Runs one instruction on the model in issue order and returns its beat
function automatic resultBus_t refExecute(input instruction_t ins);
	resultBus_t             expRes;
	logic [`DATA_WIDTH-1:0] a;
	logic [`DATA_WIDTH-1:0] b;
	logic [`DATA_WIDTH-1:0] imm;
	logic [`DATA_WIDTH-1:0] v;
	logic                   legal;
	a     = regVal(ins.Ra);
	b     = regVal(ins.Rb);
	// Instruction bits 31..19 read as a signed number
	imm   = `DATA_WIDTH'($signed(ins[31:19]));
	v     = '0;
	legal = 1'b1;
	case (ins.opcode)
		OP_R2:
		begin
			case (ins.tail)
				FN_ADD:  v = a + b;
				FN_SUB:  v = a - b;
				FN_CMP:  v = cmpVal(a, b);
				FN_MUL:  v = a * b;
				FN_AND:  v = a & b;
				FN_OR:   v = a | b;
				FN_EOR:  v = a ^ b;
				FN_ANDC: v = a & ~b;
				FN_NAND: v = ~(a & b);
				FN_NOR:  v = ~(a | b);
				FN_ENOR: v = ~(a ^ b);
				FN_ORC:  v = a | ~b;
				FN_SEQ:  v[0] = (a == b);
				FN_SNE:  v[0] = (a != b);
				FN_SLT:  v[0] = ($signed(a) < $signed(b));
				FN_SLE:  v[0] = ($signed(a) <= $signed(b));
				FN_SLTU: v[0] = (a < b);
				FN_SLEU: v[0] = (a <= b);
				default: legal = 1'b0;
			endcase
		end
		OP_ADDI:  v = a + imm;
		// Subtract from immediate, operands swapped
		OP_SUBFI: v = imm - a;
		OP_CMPI:  v = cmpVal(a, imm);
		OP_MULI:  v = a * imm;
		OP_SLTI:  v[0] = ($signed(a) < $signed(imm));
		OP_ANDI:  v = a & imm;
		OP_ORI:   v = a | imm;
		OP_EORI:  v = a ^ imm;
		OP_MOV:   v = a;
		default:  legal = 1'b0;
	endcase
	expRes = '0;
	if (legal)
	begin
		expRes.Rt    = ins.Rt;
		expRes.value = v;
		// Register 0 keeps reading as zero
		if (ins.Rt != '0)
			modelRegs[ins.Rt] = v;
	end
	else
		expRes.illegal = 1'b1;
	return expRes;
endfunction

`endif

// File: sim/coreTb.sv
// ========================================
// Testbench for coreTop, LFSR stimulus with a fixed seed
// Tests only read registers they have written first
// ========================================
`timescale 1ns/10ps
`include "cpuDefs.svh"

module coreTb;

	import cpuPkg::*;

	`include "tbRefModel.svh"

	// DUT ports, inputs start in a known state
	logic         clk;
	logic         rst = 1'b1;
	logic         instrValid = 1'b0;
	instruction_t instr = '0;
	logic         instrCredit;
	logic         resValid;
	resultBus_t   res;
	logic         resCredit = 1'b0;

	// Source side bookkeeping
	instruction_t pendQ [$];
	resultBus_t   expQ [$];
	int           srcCredits = `INSTR_CREDITS;
	int           sentCount = 0;
	int           creditsBack = 0;
	int           sentAtFirstCredit = -1;
	logic         firstCreditSeen = 1'b0;

	// Consumer side bookkeeping
	logic         creditEnable = 1'b1;
	int           owed = 0;
	int           beatCount = 0;
	int           checkCount = 0;
	int           errors = 0;

	func_e   fnList [18] = '{FN_ADD, FN_SUB, FN_CMP, FN_MUL, FN_AND, FN_OR, FN_EOR,
		FN_ANDC, FN_NAND, FN_NOR, FN_ENOR, FN_ORC, FN_SEQ, FN_SNE, FN_SLT, FN_SLE,
		FN_SLTU, FN_SLEU};
	opcode_e immOps [9] = '{OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_SLTI, OP_ANDI,
		OP_ORI, OP_EORI, OP_MOV};
	func_e   chainFns [4] = '{FN_ADD, FN_SUB, FN_EOR, FN_MUL};

	coreTop i_dut (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.instrCredit(instrCredit),
		.resValid   (resValid),
		.res        (res),
		.resCredit  (resCredit)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// Source, one queued instruction per cycle while credits last
	// ========================================
	always @(negedge clk)
	begin
		if (instrCredit === 1'b1)
		begin
			// Remember how far the source got on its initial credits
			if (!firstCreditSeen)
				sentAtFirstCredit = sentCount;
			firstCreditSeen = 1'b1;
			creditsBack++;
			srcCredits++;
		end
		if (pendQ.size() > 0 && srcCredits > 0)
		begin
			instr      = pendQ.pop_front();
			instrValid = 1'b1;
			srcCredits--;
			sentCount++;
			expQ.push_back(refExecute(instr));
		end
		else
			instrValid = 1'b0;
	end

	// Consumer hands back one credit per beat at random moments
	always @(negedge clk)
	begin
		if (resValid === 1'b1)
			owed++;
		resCredit = 1'b0;
		if (creditEnable && owed > 0)
		begin
			credLfsr  = lfsrNext(credLfsr);
			resCredit = credLfsr[0];
		end
		if (resCredit)
			owed--;
	end

	// ========================================
	// Comparison of every beat against the reference queue
	// ========================================
	always @(negedge clk)
	begin : checkBeats
		resultBus_t expRes;
		if (resValid === 1'b1)
		begin
			beatCount++;
			if (expQ.size() == 0)
			begin
				$display("A result beat arrived with no instruction outstanding");
				errors++;
			end
			else
			begin
				expRes = expQ.pop_front();
				checkCount += 3;
				assert (res.Rt === expRes.Rt)
				else
				begin
					$display("[FAIL] res.Rt got %h expected %h", res.Rt, expRes.Rt);
					errors++;
				end
				assert (res.value === expRes.value)
				else
				begin
					$display("[FAIL] res.value got %h expected %h", res.value, expRes.value);
					errors++;
				end
				assert (res.illegal === expRes.illegal)
				else
				begin
					$display("[FAIL] res.illegal got %h expected %h", res.illegal,
						expRes.illegal);
					errors++;
				end
			end
		end
	end

	task automatic compareInt(input string name, input int got, input int want);
		checkCount++;
		assert (got == want)
		else
		begin
			$display("[FAIL] %s got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	// Returns on a rising edge once every queued instruction has come back
	task automatic waitIdle();
		int cycles;
		cycles = 0;
		while ((pendQ.size() > 0 || expQ.size() > 0) && cycles < 2000)
		begin
			@(posedge clk);
			cycles++;
		end
		if (pendQ.size() > 0 || expQ.size() > 0)
		begin
			$display("Timed out with %0d instructions unsent and %0d results missing",
				pendQ.size(), expQ.size());
			errors++;
		end
	endtask

	task automatic reportTest(input int num, input string name, input int errsBefore);
		if (errors == errsBefore)
			$display("Test %0d %s: passed", num, name);
		else
			$display("Test %0d %s: %0d failures", num, name, errors - errsBefore);
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial
	begin : mainSeq
		int          errsBefore;
		int          beatsBefore;
		int          cycles;
		int          k;
		logic [12:0] imm;
		for (k = 0; k < `REG_COUNT; k++)
			modelRegs[k] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Idle core stays quiet, then the source spends its initial credits
		errsBefore = errors;
		repeat (8)
		begin
			@(negedge clk);
			checkCount++;
			assert (resValid === 1'b0 && instrCredit === 1'b0)
			else
			begin
				$display("[FAIL] resValid/instrCredit got %h/%h expected 0/0", resValid,
					instrCredit);
				errors++;
			end
		end
		@(posedge clk);
		for (k = 1; k <= `INSTR_CREDITS + 1; k++)
			pendQ.push_back(mkImm(OP_ORI, regspec_t'(k), '0, 13'(randBits(13))));
		waitIdle();
		compareInt("sentAtFirstCredit", sentAtFirstCredit, `INSTR_CREDITS);
		compareInt("instrCredit pulses", creditsBack, sentCount);
		reportTest(1, "reset and input credits", errsBefore);

		// Load r1..r15 through ORI, then every function code in turn on random registers
		errsBefore = errors;
		for (k = 1; k < 16; k++)
			pendQ.push_back(mkImm(OP_ORI, regspec_t'(k), '0, 13'(randBits(13))));
		for (k = 0; k < 60; k++)
			pendQ.push_back(mkR2(fnList[k % 18], regspec_t'(1 + randBelow(15)),
				regspec_t'(1 + randBelow(15)), regspec_t'(1 + randBelow(15))));
		waitIdle();
		reportTest(2, "register-register ALU", errsBefore);

		// Each immediate op sees -1, -4096, 4095 and then random immediates
		errsBefore = errors;
		for (k = 0; k < 45; k++)
		begin
			if (k < 9)
				imm = 13'h1fff;
			else if (k < 18)
				imm = 13'h1000;
			else if (k < 27)
				imm = 13'h0fff;
			else
				imm = 13'(randBits(13));
			pendQ.push_back(mkImm(immOps[k % 9], regspec_t'(16 + randBelow(16)),
				regspec_t'(1 + randBelow(15)), imm));
		end
		waitIdle();
		reportTest(3, "immediate forms and MOV", errsBefore);

		// Chain where Ra comes from the execute register and Rb from the write bypass
		errsBefore = errors;
		pendQ.push_back(mkImm(OP_ORI, 6'd32, '0, 13'(randBits(13))));
		pendQ.push_back(mkImm(OP_ORI, 6'd33, '0, 13'(randBits(13))));
		for (k = 2; k < 22; k++)
			pendQ.push_back(mkR2(chainFns[k % 4], regspec_t'(32 + k),
				regspec_t'(31 + k), regspec_t'(30 + k)));
		waitIdle();
		reportTest(4, "dependent chains", errsBefore);

		// All earlier credits must be home before withholding new ones
		errsBefore = errors;
		cycles = 0;
		while (owed > 0 && cycles < 200)
		begin
			@(posedge clk);
			cycles++;
		end
		if (owed > 0)
		begin
			$display("Timed out waiting for the consumer to return its credits");
			errors++;
		end
		creditEnable = 1'b0;
		beatsBefore = beatCount;
		for (k = 1; k <= 10; k++)
			pendQ.push_back(mkImm(OP_ADDI, regspec_t'(k), regspec_t'(k), 13'(randBits(13))));
		repeat (40) @(posedge clk);
		compareInt("beats without credit", beatCount - beatsBefore, `RES_CREDITS);
		creditEnable = 1'b1;
		waitIdle();
		compareInt("beats after credit", beatCount - beatsBefore, 10);
		reportTest(5, "output back-pressure", errsBefore);

		// Unknown opcodes and functions, then writes aimed at register 0
		errsBefore = errors;
		pendQ.push_back(mkImm(opcode_e'(7'd0), 6'd7, 6'd1, 13'h055));
		pendQ.push_back(mkImm(opcode_e'(7'd1), 6'd7, 6'd2, 13'h123));
		pendQ.push_back(mkImm(opcode_e'(7'd3), 6'd7, 6'd3, 13'h1ff));
		pendQ.push_back(mkImm(opcode_e'(7'd13), 6'd7, 6'd4, 13'h001));
		pendQ.push_back(mkImm(opcode_e'(7'd127), 6'd7, 6'd5, 13'h1000));
		pendQ.push_back(mkR2(func_e'(7'd0), 6'd8, 6'd1, 6'd2));
		pendQ.push_back(mkR2(func_e'(7'd7), 6'd8, 6'd3, 6'd4));
		pendQ.push_back(mkR2(func_e'(7'd99), 6'd8, 6'd5, 6'd6));
		pendQ.push_back(mkImm(OP_ADDI, 6'd0, 6'd1, 13'd123));
		pendQ.push_back(mkImm(OP_ORI, 6'd0, 6'd0, 13'h7ff));
		pendQ.push_back(mkR2(FN_ADD, 6'd9, 6'd0, 6'd0));
		pendQ.push_back(mkImm(OP_MOV, 6'd10, 6'd0, 13'h000));
		pendQ.push_back(mkR2(FN_OR, 6'd11, 6'd0, 6'd3));
		waitIdle();
		reportTest(6, "illegal instructions and register 0", errsBefore);

		compareInt("total beats", beatCount, sentCount);
		$display("Checks %0d, failures %0d", checkCount, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+src
+incdir+sim
src/cpuPkg.sv
src/decodeRt.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/resultStage.sv
src/coreTop.sv
sim/coreTb.sv
